// File: hw/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// CSR numbers
`define CSR_CRMD            14'h000
`define CSR_PRMD            14'h001
`define CSR_ECFG            14'h004
`define CSR_ESTAT           14'h005
`define CSR_ERA             14'h006
`define CSR_BADV            14'h007
`define CSR_EENTRY          14'h00c
`define CSR_SAVE0           14'h030
`define CSR_SAVE1           14'h031
`define CSR_SAVE2           14'h032
`define CSR_SAVE3           14'h033
`define CSR_TID             14'h040
`define CSR_TCFG            14'h041
`define CSR_TVAL            14'h042
`define CSR_TICLR           14'h044

// CRMD fields
`define CSR_CRMD_PLV        1:0
`define CSR_CRMD_IE         2
`define CSR_CRMD_DA         3
`define CSR_CRMD_PG         4

// PRMD fields
`define CSR_PRMD_PPLV       1:0
`define CSR_PRMD_PIE        2

// ECFG fields
`define CSR_ECFG_LIE        12:0

// ESTAT fields
`define CSR_ESTAT_IS10      1:0
`define CSR_ESTAT_ECODE     21:16
`define CSR_ESTAT_ESUBCODE  30:22

// EENTRY fields
`define CSR_EENTRY_VA       31:6

// TCFG fields
`define CSR_TCFG_EN         0
`define CSR_TCFG_PERIODIC   1
`define CSR_TCFG_INITV      31:2

// TICLR fields
`define CSR_TICLR_CLR       0

// Exception codes
`define ECODE_ADE           6'h08
`define ECODE_ALE           6'h09
`define ESUBCODE_ADEF       9'h000

// Bit 10 of LIE is reserved
`define ECFG_LIE_MASK       13'h1bff

// Timer interrupt line in ESTAT.IS
`define TIMER_IRQ_BIT       11

`endif

// File: hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Data word, PC or address
    typedef logic [31:0] csr_word_t;

    // CSR number as seen on the software port
    typedef logic [13:0] csr_num_t;

    // Exception code and subcode
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // Privilege level
    typedef logic [1:0]  plv_t;

endpackage

`default_nettype wire

// File: hw/csr_exc_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "csr_defs.svh"

module csr_exc_regs (
    input  wire                         clk,
    input  wire                         reset,
    input  wire csr_pkg::csr_num_t      csr_num,
    input  wire                         csr_we,
    input  wire csr_pkg::csr_word_t     csr_wmask,
    input  wire csr_pkg::csr_word_t     csr_wvalue,
    input  wire                         ertn_flush,
    input  wire                         wb_ex,
    input  wire csr_pkg::csr_word_t     wb_pc,
    input  wire csr_pkg::csr_word_t     wb_vaddr,
    input  wire csr_pkg::ecode_t        wb_ecode,
    input  wire csr_pkg::esubcode_t     wb_esubcode,
    input  wire                         timer_fire,
    output csr_pkg::csr_word_t          rdata,
    output logic                        has_int,
    output csr_pkg::csr_word_t          csr_eentry_data,
    output csr_pkg::csr_word_t          csr_era_pc
);

    csr_pkg::plv_t      crmd_plv;
    logic               crmd_ie;
    logic               crmd_da;
    logic               crmd_pg;
    csr_pkg::plv_t      prmd_pplv;
    logic               prmd_pie;
    logic [12:0]        ecfg_lie;
    logic [1:0]         estat_is10;
    logic               estat_is11;
    csr_pkg::ecode_t    estat_ecode;
    csr_pkg::esubcode_t estat_esubcode;
    logic [25:0]        eentry_va;
    csr_pkg::csr_word_t badv_vaddr;

    logic [12:0]        estat_is;
    csr_pkg::csr_word_t crmd_data;
    csr_pkg::csr_word_t prmd_data;
    csr_pkg::csr_word_t ecfg_data;
    csr_pkg::csr_word_t estat_data;

    // Masked merge of the write data with each current value
    csr_pkg::csr_word_t crmd_new;
    csr_pkg::csr_word_t prmd_new;
    csr_pkg::csr_word_t ecfg_new;
    csr_pkg::csr_word_t estat_new;
    csr_pkg::csr_word_t era_new;
    csr_pkg::csr_word_t eentry_new;

    logic sel_crmd;
    logic sel_prmd;
    logic sel_ecfg;
    logic sel_estat;
    logic sel_era;
    logic sel_badv;
    logic sel_eentry;
    logic ticlr_clr;
    logic ex_addr_err;

    assign sel_crmd   = csr_num == `CSR_CRMD;
    assign sel_prmd   = csr_num == `CSR_PRMD;
    assign sel_ecfg   = csr_num == `CSR_ECFG;
    assign sel_estat  = csr_num == `CSR_ESTAT;
    assign sel_era    = csr_num == `CSR_ERA;
    assign sel_badv   = csr_num == `CSR_BADV;
    assign sel_eentry = csr_num == `CSR_EENTRY;

    assign ticlr_clr = csr_we && csr_num == `CSR_TICLR
                       && csr_wmask[`CSR_TICLR_CLR] && csr_wvalue[`CSR_TICLR_CLR];

    assign crmd_new   = (csr_wmask & csr_wvalue) | (~csr_wmask & crmd_data);
    assign prmd_new   = (csr_wmask & csr_wvalue) | (~csr_wmask & prmd_data);
    assign ecfg_new   = (csr_wmask & csr_wvalue) | (~csr_wmask & ecfg_data);
    assign estat_new  = (csr_wmask & csr_wvalue) | (~csr_wmask & estat_data);
    assign era_new    = (csr_wmask & csr_wvalue) | (~csr_wmask & csr_era_pc);
    assign eentry_new = (csr_wmask & csr_wvalue) | (~csr_wmask & csr_eentry_data);

    // PLV and IE move on exception entry and return
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && sel_crmd) begin
            crmd_plv <= crmd_new[`CSR_CRMD_PLV];
            crmd_ie  <= crmd_new[`CSR_CRMD_IE];
        end
    end

    // DA and PG only change by software
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_da <= 1'b1;
            crmd_pg <= 1'b0;
        end else if (csr_we && sel_crmd) begin
            crmd_da <= crmd_new[`CSR_CRMD_DA];
            crmd_pg <= crmd_new[`CSR_CRMD_PG];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && sel_prmd) begin
            prmd_pplv <= prmd_new[`CSR_PRMD_PPLV];
            prmd_pie  <= prmd_new[`CSR_PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (csr_we && sel_ecfg) begin
            ecfg_lie <= ecfg_new[`CSR_ECFG_LIE] & `ECFG_LIE_MASK;
        end
    end

    // Software interrupt bits
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is10 <= '0;
        end else if (csr_we && sel_estat) begin
            estat_is10 <= estat_new[`CSR_ESTAT_IS10];
        end
    end

    // Timer interrupt, a new timer event wins over TICLR
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is11 <= 1'b0;
        end else if (timer_fire) begin
            estat_is11 <= 1'b1;
        end else if (ticlr_clr) begin
            estat_is11 <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            csr_era_pc <= '0;
        end else if (wb_ex) begin
            csr_era_pc <= wb_pc;
        end else if (csr_we && sel_era) begin
            csr_era_pc <= era_new;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_va <= '0;
        end else if (csr_we && sel_eentry) begin
            eentry_va <= eentry_new[`CSR_EENTRY_VA];
        end
    end

    // BADV is loaded only by address errors
    assign ex_addr_err = wb_ecode == `ECODE_ADE || wb_ecode == `ECODE_ALE;

    always_ff @(posedge clk) begin
        if (reset) begin
            badv_vaddr <= '0;
        end else if (wb_ex && ex_addr_err) begin
            badv_vaddr <= (wb_ecode == `ECODE_ADE && wb_esubcode == `ESUBCODE_ADEF)
                          ? wb_pc : wb_vaddr;
        end
    end

    always_comb begin
        estat_is                    = '0;
        estat_is[`CSR_ESTAT_IS10]   = estat_is10;
        estat_is[`TIMER_IRQ_BIT]    = estat_is11;
        estat_data                  = '0;
        estat_data[12:0]            = estat_is;
        estat_data[`CSR_ESTAT_ECODE]    = estat_ecode;
        estat_data[`CSR_ESTAT_ESUBCODE] = estat_esubcode;
    end

    assign crmd_data       = {27'b0, crmd_pg, crmd_da, crmd_ie, crmd_plv};
    assign prmd_data       = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg_data       = {19'b0, ecfg_lie};
    assign csr_eentry_data = {eentry_va, 6'b0};

    assign has_int = (|(estat_is & ecfg_lie)) && crmd_ie;

    // TICLR is owned here but reads zero
    assign rdata = {32{sel_crmd}}   & crmd_data
                 | {32{sel_prmd}}   & prmd_data
                 | {32{sel_ecfg}}   & ecfg_data
                 | {32{sel_estat}}  & estat_data
                 | {32{sel_era}}    & csr_era_pc
                 | {32{sel_badv}}   & badv_vaddr
                 | {32{sel_eentry}} & csr_eentry_data;

    a_ex_ertn_excl: assert property (@(posedge clk) disable iff (reset)
        !(wb_ex && ertn_flush))
        else $error("wb_ex and ertn_flush asserted together");

    a_ex_plv0: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> crmd_plv == '0)
        else $error("CRMD.PLV not cleared after exception entry");

endmodule

`default_nettype wire

// File: hw/csr_timer.sv
`timescale 1ns/10ps
`default_nettype none
`include "csr_defs.svh"

module csr_timer (
    input  wire                         clk,
    input  wire                         reset,
    input  wire csr_pkg::csr_num_t      csr_num,
    input  wire                         csr_we,
    input  wire csr_pkg::csr_word_t     csr_wmask,
    input  wire csr_pkg::csr_word_t     csr_wvalue,
    output csr_pkg::csr_word_t          rdata,
    output logic                        timer_fire
);

    logic               tcfg_en;
    logic               tcfg_periodic;
    logic [29:0]        tcfg_initv;
    csr_pkg::csr_word_t timer_cnt;

    csr_pkg::csr_word_t tcfg_data;
    csr_pkg::csr_word_t tcfg_new;
    logic               sel_tcfg;
    logic               sel_tval;
    logic               tcfg_wr;

    assign sel_tcfg = csr_num == `CSR_TCFG;
    assign sel_tval = csr_num == `CSR_TVAL;
    assign tcfg_wr  = csr_we && sel_tcfg;

    assign tcfg_data = {tcfg_initv, tcfg_periodic, tcfg_en};
    assign tcfg_new  = (csr_wmask & csr_wvalue) | (~csr_wmask & tcfg_data);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initv    <= '0;
        end else if (tcfg_wr) begin
            tcfg_en       <= tcfg_new[`CSR_TCFG_EN];
            tcfg_periodic <= tcfg_new[`CSR_TCFG_PERIODIC];
            tcfg_initv    <= tcfg_new[`CSR_TCFG_INITV];
        end
    end

    // Countdown, a one-shot timer parks at all ones after zero
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= '1;
        end else if (tcfg_wr && tcfg_new[`CSR_TCFG_EN]) begin
            timer_cnt <= {tcfg_new[`CSR_TCFG_INITV], 2'b00};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initv, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    assign timer_fire = tcfg_en && timer_cnt == '0;

    // TVAL is read only
    assign rdata = {32{sel_tcfg}} & tcfg_data
                 | {32{sel_tval}} & timer_cnt;

    a_cnt_frozen: assert property (@(posedge clk) disable iff (reset)
        (!tcfg_en && !tcfg_wr) |=> $stable(timer_cnt))
        else $error("timer counter moved while stopped");

endmodule

`default_nettype wire

// File: hw/csr_scratch_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "csr_defs.svh"

module csr_scratch_regs (
    input  wire                         clk,
    input  wire                         reset,
    input  wire csr_pkg::csr_num_t      csr_num,
    input  wire                         csr_we,
    input  wire csr_pkg::csr_word_t     csr_wmask,
    input  wire csr_pkg::csr_word_t     csr_wvalue,
    output csr_pkg::csr_word_t          rdata
);

    csr_pkg::csr_word_t save_q [4];
    csr_pkg::csr_word_t tid_q;
    logic [3:0]         sel_save;
    logic               sel_tid;

    // SAVE0..3 are consecutive numbers
    assign sel_save[0] = csr_num == `CSR_SAVE0;
    assign sel_save[1] = csr_num == `CSR_SAVE1;
    assign sel_save[2] = csr_num == `CSR_SAVE2;
    assign sel_save[3] = csr_num == `CSR_SAVE3;
    assign sel_tid     = csr_num == `CSR_TID;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
            tid_q <= '0;
        end else if (csr_we) begin
            for (int i = 0; i < 4; i++) begin
                if (sel_save[i]) begin
                    save_q[i] <= (csr_wmask & csr_wvalue) | (~csr_wmask & save_q[i]);
                end
            end
            if (sel_tid) begin
                tid_q <= (csr_wmask & csr_wvalue) | (~csr_wmask & tid_q);
            end
        end
    end

    assign rdata = {32{sel_save[0]}} & save_q[0]
                 | {32{sel_save[1]}} & save_q[1]
                 | {32{sel_save[2]}} & save_q[2]
                 | {32{sel_save[3]}} & save_q[3]
                 | {32{sel_tid}}     & tid_q;

    a_rdata_unowned: assert property (@(posedge clk) disable iff (reset)
        !(csr_num inside {`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID})
        |-> rdata == '0)
        else $error("scratch bank drives data for a foreign CSR");

endmodule

`default_nettype wire

// File: hw/csr_regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "csr_defs.svh"

module csr_regfile (
    input  wire                         clk,
    input  wire                         reset,
    input  wire csr_pkg::csr_num_t      csr_num,
    input  wire                         csr_we,
    input  wire csr_pkg::csr_word_t     csr_wmask,
    input  wire csr_pkg::csr_word_t     csr_wvalue,
    input  wire                         ertn_flush,
    input  wire                         wb_ex,
    input  wire csr_pkg::csr_word_t     wb_pc,
    input  wire csr_pkg::csr_word_t     wb_vaddr,
    input  wire csr_pkg::ecode_t        wb_ecode,
    input  wire csr_pkg::esubcode_t     wb_esubcode,
    output csr_pkg::csr_word_t          csr_rvalue,
    output logic                        has_int,
    output csr_pkg::csr_word_t          csr_eentry_data,
    output csr_pkg::csr_word_t          csr_era_pc
);

    csr_pkg::csr_word_t exc_rdata;
    csr_pkg::csr_word_t tmr_rdata;
    csr_pkg::csr_word_t scr_rdata;
    logic               timer_fire;

    csr_exc_regs i_exc_regs (
        .clk             (clk),
        .reset           (reset),
        .csr_num         (csr_num),
        .csr_we          (csr_we),
        .csr_wmask       (csr_wmask),
        .csr_wvalue      (csr_wvalue),
        .ertn_flush      (ertn_flush),
        .wb_ex           (wb_ex),
        .wb_pc           (wb_pc),
        .wb_vaddr        (wb_vaddr),
        .wb_ecode        (wb_ecode),
        .wb_esubcode     (wb_esubcode),
        .timer_fire      (timer_fire),
        .rdata           (exc_rdata),
        .has_int         (has_int),
        .csr_eentry_data (csr_eentry_data),
        .csr_era_pc      (csr_era_pc)
    );

    csr_timer i_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rdata      (tmr_rdata),
        .timer_fire (timer_fire)
    );

    csr_scratch_regs i_scratch_regs (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rdata      (scr_rdata)
    );

    // Banks drive zero for numbers they do not own
    assign csr_rvalue = exc_rdata | tmr_rdata | scr_rdata;

endmodule

`default_nettype wire

// File: sim/csr_regfile_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "csr_defs.svh"

module csr_regfile_tb;

    localparam int ROWS = 128;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_EXC, OP_RET, OP_IDLE, OP_INT, OP_ERA, OP_EENTRY
    } op_t;

    // Exception rows carry wb_pc in mask and wb_vaddr in value
    typedef struct packed {
        op_t                op;
        csr_pkg::csr_num_t  num;
        csr_pkg::csr_word_t mask;
        csr_pkg::csr_word_t value;
        csr_pkg::ecode_t    ecode;
        csr_pkg::esubcode_t esub;
        csr_pkg::csr_word_t exp;
    } row_t;

    logic               clk;
    logic               reset;
    csr_pkg::csr_num_t  csr_num;
    logic               csr_we;
    csr_pkg::csr_word_t csr_wmask;
    csr_pkg::csr_word_t csr_wvalue;
    logic               ertn_flush;
    logic               wb_ex;
    csr_pkg::csr_word_t wb_pc;
    csr_pkg::csr_word_t wb_vaddr;
    csr_pkg::ecode_t    wb_ecode;
    csr_pkg::esubcode_t wb_esubcode;
    csr_pkg::csr_word_t csr_rvalue;
    logic               has_int;
    csr_pkg::csr_word_t csr_eentry_data;
    csr_pkg::csr_word_t csr_era_pc;

    row_t               rows [ROWS];
    int                 n_rows;
    int                 table_cycles;
    int                 cycle_limit;
    int                 cycle_cnt;
    integer             seed;

    // Expected CSR contents by number
    csr_pkg::csr_word_t model [16384];

    csr_regfile i_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input csr_pkg::csr_word_t actual,
                         input csr_pkg::csr_word_t expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // Bits that software can write, per field map
    function automatic csr_pkg::csr_word_t writable_bits(input csr_pkg::csr_num_t num);
        case (num)
            `CSR_CRMD:   return 32'h0000_001f;
            `CSR_PRMD:   return 32'h0000_0007;
            `CSR_ECFG:   return {19'b0, `ECFG_LIE_MASK};
            `CSR_ESTAT:  return 32'h0000_0003;
            `CSR_EENTRY: return 32'hffff_ffc0;
            `CSR_ERA, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID, `CSR_TCFG:
                return 32'hffff_ffff;
            default:     return 32'h0000_0000;
        endcase
    endfunction

    task automatic push_row(input op_t op, input csr_pkg::csr_num_t num,
                            input csr_pkg::csr_word_t mask, input csr_pkg::csr_word_t value,
                            input csr_pkg::ecode_t ecode, input csr_pkg::esubcode_t esub,
                            input csr_pkg::csr_word_t exp, input int cycles);
        row_t r;
        r.op    = op;
        r.num   = num;
        r.mask  = mask;
        r.value = value;
        r.ecode = ecode;
        r.esub  = esub;
        r.exp   = exp;
        rows[n_rows] = r;
        n_rows++;
        table_cycles += cycles;
    endtask

    task automatic add_write(input csr_pkg::csr_num_t num, input csr_pkg::csr_word_t mask,
                             input csr_pkg::csr_word_t value);
        csr_pkg::csr_word_t wbits;
        wbits = writable_bits(num) & mask;
        push_row(OP_WRITE, num, mask, value, '0, '0, '0, 1);
        model[num] = (model[num] & ~wbits) | (value & wbits);
    endtask

    task automatic add_read(input csr_pkg::csr_num_t num);
        push_row(OP_READ, num, '0, '0, '0, '0, model[num], 1);
    endtask

    task automatic add_read_exp(input csr_pkg::csr_num_t num, input csr_pkg::csr_word_t exp);
        push_row(OP_READ, num, '0, '0, '0, '0, exp, 1);
    endtask

    task automatic add_idle(input int n);
        push_row(OP_IDLE, '0, '0, n, '0, '0, '0, n);
    endtask

    task automatic add_exc(input csr_pkg::csr_word_t pc, input csr_pkg::csr_word_t vaddr,
                           input csr_pkg::ecode_t ecode, input csr_pkg::esubcode_t esub);
        push_row(OP_EXC, '0, pc, vaddr, ecode, esub, '0, 1);
        // PLV and IE saved in PRMD, then cleared
        model[`CSR_PRMD]      = {29'b0, model[`CSR_CRMD][2:0]};
        model[`CSR_CRMD][2:0] = 3'b000;
        model[`CSR_ERA]       = pc;
        model[`CSR_ESTAT][`CSR_ESTAT_ECODE]    = ecode;
        model[`CSR_ESTAT][`CSR_ESTAT_ESUBCODE] = esub;
        if (ecode == `ECODE_ADE || ecode == `ECODE_ALE) begin
            model[`CSR_BADV] = (ecode == `ECODE_ADE && esub == `ESUBCODE_ADEF) ? pc : vaddr;
        end
    endtask

    task automatic add_ret();
        push_row(OP_RET, '0, '0, '0, '0, '0, '0, 1);
        model[`CSR_CRMD][2:0] = model[`CSR_PRMD][2:0];
    endtask

    task automatic add_masked_pair(input csr_pkg::csr_num_t num, input csr_pkg::csr_word_t mask);
        csr_pkg::csr_word_t first;
        csr_pkg::csr_word_t second;
        first  = $random(seed);
        second = $random(seed);
        add_write(num, 32'hffff_ffff, first);
        add_write(num, mask, second);
        add_read(num);
    endtask

    task automatic build_table();
        n_rows       = 0;
        table_cycles = 0;
        for (int i = 0; i < 16384; i++) begin
            model[i] = '0;
        end
        model[`CSR_CRMD] = 32'h0000_0008;

        // Reset values
        add_read(`CSR_CRMD);
        add_read(`CSR_PRMD);
        add_read(`CSR_ECFG);
        add_read(`CSR_ESTAT);
        add_read(`CSR_ERA);
        add_read(`CSR_BADV);
        add_read(`CSR_EENTRY);
        add_read(`CSR_SAVE0);
        add_read(`CSR_TID);
        add_read(`CSR_TCFG);
        add_read_exp(`CSR_TVAL, 32'hffff_ffff);
        push_row(OP_INT, '0, '0, '0, '0, '0, 32'h0, 1);

        // Masked writes
        add_masked_pair(`CSR_SAVE0, 32'h0000_ffff);
        add_masked_pair(`CSR_SAVE1, 32'hffff_0000);
        add_masked_pair(`CSR_SAVE2, 32'hf0f0_f0f0);
        add_masked_pair(`CSR_SAVE3, 32'h0ff0_00ff);
        add_masked_pair(`CSR_TID, 32'h8421_1248);
        add_write(`CSR_EENTRY, 32'hffff_ffff, 32'h1c00_8fff);
        add_read(`CSR_EENTRY);
        add_write(`CSR_EENTRY, 32'hffff_0000, 32'h2345_ffff);
        add_read(`CSR_EENTRY);
        push_row(OP_EENTRY, '0, '0, '0, '0, '0, model[`CSR_EENTRY], 1);
        add_write(`CSR_ECFG, 32'hffff_ffff, 32'hffff_ffff);
        add_read(`CSR_ECFG);
        add_write(`CSR_ECFG, 32'hffff_ffff, 32'h0);
        add_write(14'h002, 32'hffff_ffff, 32'hffff_ffff);
        add_read(14'h002);
        add_read(14'h043);
        add_read(14'h3fff);
        add_read(`CSR_TICLR);

        // Exception entry and return
        add_write(`CSR_CRMD, 32'h0000_0007, 32'h0000_0007);
        add_exc(32'h1c00_1000, 32'h0bad_0001, `ECODE_ADE, `ESUBCODE_ADEF);
        add_read(`CSR_CRMD);
        add_read(`CSR_PRMD);
        push_row(OP_ERA, '0, '0, '0, '0, '0, model[`CSR_ERA], 1);
        add_read(`CSR_ERA);
        add_read(`CSR_ESTAT);
        add_read(`CSR_BADV);
        add_ret();
        add_read(`CSR_CRMD);
        add_exc(32'h1c00_2004, 32'h8000_0003, `ECODE_ALE, 9'h000);
        add_read(`CSR_ESTAT);
        add_read(`CSR_BADV);
        add_ret();
        add_exc(32'h1c00_3008, 32'hdead_beef, 6'h0b, 9'h001);
        add_read(`CSR_BADV);
        add_read(`CSR_ESTAT);
        add_ret();
        add_read(`CSR_CRMD);

        // One-shot timer, INITV 4 counts from 16
        add_write(`CSR_CRMD, 32'h0000_0004, 32'h0);
        add_write(`CSR_TCFG, 32'hffff_ffff, {30'd4, 2'b01});
        add_idle(3);
        add_read_exp(`CSR_TVAL, 32'd16 - 32'd3);
        add_idle(16);
        model[`CSR_ESTAT][`TIMER_IRQ_BIT] = 1'b1;
        add_read(`CSR_ESTAT);
        add_read_exp(`CSR_TVAL, 32'hffff_ffff);

        // Interrupt gating and clear
        push_row(OP_INT, '0, '0, '0, '0, '0, 32'h0, 1);
        add_write(`CSR_ECFG, 32'h0000_0800, 32'h0000_0800);
        push_row(OP_INT, '0, '0, '0, '0, '0, 32'h0, 1);
        add_write(`CSR_CRMD, 32'h0000_0004, 32'h0000_0004);
        push_row(OP_INT, '0, '0, '0, '0, '0, 32'h1, 1);
        add_write(`CSR_TICLR, 32'h0000_0001, 32'h0000_0001);
        model[`CSR_ESTAT][`TIMER_IRQ_BIT] = 1'b0;
        add_read(`CSR_ESTAT);
        push_row(OP_INT, '0, '0, '0, '0, '0, 32'h0, 1);
        add_write(`CSR_ECFG, 32'h0000_0001, 32'h0000_0001);
        add_write(`CSR_ESTAT, 32'h0000_0003, 32'h0000_0001);
        push_row(OP_INT, '0, '0, '0, '0, '0, 32'h1, 1);
        add_read(`CSR_ESTAT);

        // Periodic timer, INITV 2 reloads 8 every 9 cycles
        add_write(`CSR_TCFG, 32'hffff_ffff, {30'd2, 2'b11});
        add_read_exp(`CSR_TVAL, 32'd8);
        add_idle(8);
        add_read_exp(`CSR_TVAL, 32'd8);
        model[`CSR_ESTAT][`TIMER_IRQ_BIT] = 1'b1;
        add_read(`CSR_ESTAT);
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk);
        #1;
        csr_we     = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
        case (r.op)
            OP_WRITE: begin
                csr_num    = r.num;
                csr_wmask  = r.mask;
                csr_wvalue = r.value;
                csr_we     = 1'b1;
            end
            OP_READ: begin
                csr_num = r.num;
                #2;
                check($sformatf("csr_rvalue(csr 0x%03h)", r.num), csr_rvalue, r.exp);
            end
            OP_EXC: begin
                wb_pc       = r.mask;
                wb_vaddr    = r.value;
                wb_ecode    = r.ecode;
                wb_esubcode = r.esub;
                wb_ex       = 1'b1;
            end
            OP_RET: begin
                ertn_flush = 1'b1;
            end
            OP_IDLE: begin
                repeat (r.value - 1) @(posedge clk);
            end
            OP_INT: begin
                #2;
                check("has_int", {31'b0, has_int}, r.exp);
            end
            OP_ERA: begin
                #2;
                check("csr_era_pc", csr_era_pc, r.exp);
            end
            OP_EENTRY: begin
                #2;
                check("csr_eentry_data", csr_eentry_data, r.exp);
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        ertn_flush  = 1'b0;
        wb_ex       = 1'b0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        seed        = 32'h6810;
        cycle_cnt   = 0;
        build_table();
        cycle_limit = table_cycles + 20;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
        end
        @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_regfile.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_exc_regs.sv
hw/csr_timer.sv
hw/csr_scratch_regs.sv
hw/csr_regfile.sv
sim/csr_regfile_tb.sv
